// File: src/pmrq_pkg.sv
// Shared load path types: data words, tags, size encodings, queue entry, memory and writeback buses
package pmrq_pkg;

    typedef logic [63:0] bus64_t;    // Full data word
    typedef logic [4:0]  reg_addr_t; // Destination register index

    // Access size, matches funct3[1:0] of the load opcodes
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10,
        SIZE_D = 2'b11
    } mem_size_e;

    localparam int unsigned PMRQ_MAX_ENTRIES = 16;                       // Deepest legal queue
    localparam int unsigned TAG_W            = $clog2(PMRQ_MAX_ENTRIES); // Covers any depth

    typedef logic [TAG_W-1:0] pmrq_tag_t;

    // One load as it travels from issue to writeback
    typedef struct packed {
        logic      valid;
        bus64_t    base;       // rs1 value
        logic [11:0] offset;   // Signed immediate
        reg_addr_t rd;
        mem_size_e size;
        logic      is_signed;
        logic      misaligned; // Raised by issue, becomes the exception
        bus64_t    addr;       // Effective address
        bus64_t    imm;        // Load result once replayed
    } load_instr_t;

    typedef struct packed {
        logic      valid;      // Single-cycle strobe, no back-pressure
        pmrq_tag_t tag;
        bus64_t    addr;       // Doubleword aligned
        mem_size_e size;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        pmrq_tag_t tag;
        bus64_t    data;       // Raw doubleword, lanes picked later
    } mem_resp_t;

    // Raw response word seen lane by lane
    typedef union packed {
        bus64_t           dword;
        logic [1:0][31:0] words;
        logic [3:0][15:0] halves;
        logic [7:0][7:0]  bytes;
    } load_data_u;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        bus64_t    data;
        logic      exception;  // Misaligned load
    } wb_t;

endpackage

// File: src/load_issue_unit.sv
// Load issue: effective address, alignment check, tag counter and registered memory request
module load_issue_unit import pmrq_pkg::*; #(
    parameter int unsigned NUM_ENTRIES = 8
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  load_instr_t instr_i,   // Only base, offset, rd, size, is_signed used
    input  logic        accept_i,  // Queue not full
    input  logic        flush_i,
    output load_instr_t instr_o,   // Enriched entry for the queue
    output pmrq_tag_t   tag_o,     // Equals queue tail slot
    output mem_req_t    mem_req_o
);

    bus64_t    eff_addr;
    logic      misaligned;
    logic      accepted;
    pmrq_tag_t tag_q;

    logic      req_valid_q;
    pmrq_tag_t req_tag_q;
    bus64_t    req_addr_q;
    mem_size_e req_size_q;

    assign eff_addr = instr_i.base + {{52{instr_i.offset[11]}}, instr_i.offset};
    assign accepted = instr_i.valid & accept_i;

    // Natural alignment per access size
    always_comb begin
        case (instr_i.size)
            SIZE_B:  misaligned = 1'b0;
            SIZE_H:  misaligned = eff_addr[0];
            SIZE_W:  misaligned = |eff_addr[1:0];
            default: misaligned = |eff_addr[2:0];
        endcase
    end

    always_comb begin
        instr_o            = instr_i;
        instr_o.valid      = accepted;      // Queue writes on this alone
        instr_o.addr       = eff_addr;
        instr_o.misaligned = misaligned;
        instr_o.imm        = '0;            // Filled by replay
    end

    assign tag_o = tag_q;

    // Tag tracks the tail slot, wraps at depth
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tag_q <= '0;
        end else if (flush_i) begin
            tag_q <= '0;
        end else if (accepted) begin
            tag_q <= (tag_q == pmrq_tag_t'(NUM_ENTRIES - 1)) ? '0 : tag_q + 1'b1;
        end
    end

    // Request strobe, aligned loads only
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= accepted & ~misaligned & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accepted) begin
            req_tag_q  <= tag_q;
            req_addr_q <= {eff_addr[63:3], 3'b000}; // Whole doubleword fetched
            req_size_q <= instr_i.size;
        end
    end

    assign mem_req_o = '{valid: req_valid_q, tag: req_tag_q, addr: req_addr_q, size: req_size_q};

    // Tag only moves with an accepted load or a flush
    a_tag_needs_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (!accepted && !flush_i) |=> $stable(tag_q));

endmodule

// File: src/pending_mem_req_queue.sv
// Pending memory request queue: in-order circular buffer of loads, tag-matched replay, head output
module pending_mem_req_queue import pmrq_pkg::*; #(
    parameter int unsigned NUM_ENTRIES = 8
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  load_instr_t instruction_i,  // New load, valid when accepted
    input  pmrq_tag_t   tag_i,          // Its tag
    input  logic        replay_valid_i, // Response result arriving
    input  pmrq_tag_t   tag_next_i,     // Which load it belongs to
    input  bus64_t      replay_data_i,  // Extended load value
    input  logic        flush_i,        // Drop everything
    input  logic        advance_head_i, // Head retired
    output load_instr_t finish_instr_o, // Head entry, zero unless ready
    output logic        full_o
);

    localparam int unsigned PTR_W = $clog2(NUM_ENTRIES);
    localparam int unsigned CNT_W = PTR_W + 1; // Must hold NUM_ENTRIES itself

    localparam logic [CNT_W-1:0] DEPTH    = CNT_W'(NUM_ENTRIES);
    localparam logic [CNT_W-1:0] FULL_THR = CNT_W'(NUM_ENTRIES - 3); // Slack for loads in flight

    logic [PTR_W-1:0] head_q;   // Oldest entry
    logic [PTR_W-1:0] tail_q;   // Next free entry
    logic [CNT_W-1:0] count_q;

    logic write_en;
    logic advance_en;
    logic head_ready;

    load_instr_t              instr_table [NUM_ENTRIES];
    pmrq_tag_t                tag_table   [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0]   ready_q;   // Result present

    assign write_en   = instruction_i.valid & (count_q < DEPTH);
    assign advance_en = advance_head_i & (count_q != '0);

    // Payload tables
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            instr_table[tail_q] <= instruction_i;
            tag_table[tail_q]   <= tag_i;
        end
        if (replay_valid_i) begin
            for (int j = 0; j < NUM_ENTRIES; j++) begin
                if (tag_table[j] == tag_next_i) begin
                    instr_table[j].imm <= replay_data_i; // Result overwrites imm
                end
            end
        end
    end

    // Ready bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ready_q <= '0;
        end else if (flush_i) begin
            ready_q <= '0;
        end else begin
            if (write_en) begin
                ready_q[tail_q] <= instruction_i.misaligned; // Nothing to wait for
            end
            if (replay_valid_i) begin
                for (int j = 0; j < NUM_ENTRIES; j++) begin
                    if (tag_table[j] == tag_next_i) begin
                        ready_q[j] <= 1'b1;
                    end
                end
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0; // Realigns with tag 0 in issue
            count_q <= '0;
        end else begin
            head_q  <= head_q + PTR_W'(advance_en);
            tail_q  <= tail_q + PTR_W'(write_en);
            count_q <= count_q + CNT_W'(write_en) - CNT_W'(advance_en);
        end
    end

    assign head_ready = (count_q != '0) & ready_q[head_q];

    assign finish_instr_o = head_ready ? instr_table[head_q] : '0;

    // Early full so the cycle in flight still fits
    assign full_o = (count_q >= FULL_THR) | flush_i | ~rstn_i;

    // Issue side must respect full
    a_no_write_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instruction_i.valid |-> (count_q < DEPTH));

    // Drain only retires something that is there
    a_no_advance_when_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        advance_head_i |-> (count_q != '0));

endmodule

// File: src/load_response_unit.sv
// Load response: per-tag side info, lane extraction with sign/zero extension, registered replay
module load_response_unit import pmrq_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  mem_resp_t  mem_resp_i,
    input  logic       alloc_valid_i,  // Aligned load accepted
    input  pmrq_tag_t  alloc_tag_i,    // Its tag
    input  mem_size_e  size_i,
    input  logic       is_signed_i,
    input  logic [2:0] byte_off_i,     // Address bits below the doubleword
    output logic       replay_valid_o,
    output pmrq_tag_t  replay_tag_o,
    output bus64_t     replay_data_o
);

    // Side info per tag, written at acceptance
    mem_size_e  size_tab [PMRQ_MAX_ENTRIES];
    logic       sign_tab [PMRQ_MAX_ENTRIES];
    logic [2:0] off_tab  [PMRQ_MAX_ENTRIES];

    logic [PMRQ_MAX_ENTRIES-1:0] pend_q; // Issued, not yet answered

    load_data_u raw;
    mem_size_e  rsp_size;
    logic       rsp_signed;
    logic [2:0] rsp_off;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] lane_w;
    bus64_t     ext_data;

    logic      replay_valid_q;
    pmrq_tag_t replay_tag_q;
    bus64_t    replay_data_q;

    always_ff @(posedge clk_i) begin
        if (alloc_valid_i) begin
            size_tab[alloc_tag_i] <= size_i;
            sign_tab[alloc_tag_i] <= is_signed_i;
            off_tab[alloc_tag_i]  <= byte_off_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pend_q <= '0;
        end else begin
            if (alloc_valid_i) begin
                pend_q[alloc_tag_i] <= 1'b1;
            end
            if (mem_resp_i.valid) begin
                pend_q[mem_resp_i.tag] <= 1'b0; // Answered
            end
        end
    end

    assign raw        = mem_resp_i.data;
    assign rsp_size   = size_tab[mem_resp_i.tag];
    assign rsp_signed = sign_tab[mem_resp_i.tag];
    assign rsp_off    = off_tab[mem_resp_i.tag];

    // Aligned access, so the offset picks a whole lane
    assign lane_b = raw.bytes[rsp_off];
    assign lane_h = raw.halves[rsp_off[2:1]];
    assign lane_w = raw.words[rsp_off[2]];

    always_comb begin
        case (rsp_size)
            SIZE_B:  ext_data = {{56{rsp_signed & lane_b[7]}}, lane_b};
            SIZE_H:  ext_data = {{48{rsp_signed & lane_h[15]}}, lane_h};
            SIZE_W:  ext_data = {{32{rsp_signed & lane_w[31]}}, lane_w};
            default: ext_data = raw.dword;   // Full doubleword
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            replay_valid_q <= 1'b0;
        end else begin
            replay_valid_q <= mem_resp_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_resp_i.valid) begin
            replay_tag_q  <= mem_resp_i.tag;
            replay_data_q <= ext_data;
        end
    end

    assign replay_valid_o = replay_valid_q;
    assign replay_tag_o   = replay_tag_q;
    assign replay_data_o  = replay_data_q;

    // Memory answers only what was asked, once
    a_resp_tag_pending: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_resp_i.valid |-> pend_q[mem_resp_i.tag]);

endmodule

// File: src/wb_drain.sv
// Writeback drain: retires ready head entries in order into a registered writeback port
module wb_drain import pmrq_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        flush_i,
    input  load_instr_t finish_instr_i, // Queue head, zero unless ready
    output logic        advance_head_o, // Pop head this cycle
    output wb_t         wb_o
);

    logic      wb_valid_q;
    reg_addr_t wb_rd_q;
    bus64_t    wb_data_q;
    logic      wb_exc_q;

    // Pop in the same cycle the head is captured
    assign advance_head_o = finish_instr_i.valid;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= finish_instr_i.valid & ~flush_i; // Flushed head never writes
        end
    end

    // Writeback payload
    always_ff @(posedge clk_i) begin
        if (finish_instr_i.valid) begin
            wb_rd_q   <= finish_instr_i.rd;
            wb_data_q <= finish_instr_i.imm;
            wb_exc_q  <= finish_instr_i.misaligned;
        end
    end

    assign wb_o = '{
        valid:     wb_valid_q,
        rd:        wb_rd_q,
        data:      wb_data_q,
        exception: wb_exc_q
    };

    // Each writeback matches one pop of the queue head
    a_wb_one_per_advance: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.valid |-> $past(advance_head_o));

endmodule

// File: src/mem_load_unit_top.sv
// Memory stage load path top: issue, pending queue, response decode and writeback drain
module mem_load_unit_top import pmrq_pkg::*; #(
    parameter int unsigned NUM_ENTRIES = 8   // 4 to 16, power of two
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  load_instr_t instr_i,
    input  logic        flush_i,
    input  mem_resp_t   mem_resp_i,
    output mem_req_t    mem_req_o,
    output wb_t         wb_o,
    output logic        full_o
);

    load_instr_t iss_instr;    // Issue to queue
    pmrq_tag_t   iss_tag;
    logic        alloc_valid;  // Aligned load heading to memory
    logic        replay_valid;
    pmrq_tag_t   replay_tag;
    bus64_t      replay_data;
    load_instr_t head_instr;   // Queue to drain
    logic        advance_head;

    assign alloc_valid = iss_instr.valid & ~iss_instr.misaligned;

    load_issue_unit #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_load_issue_unit (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .instr_i   (instr_i),
        .accept_i  (~full_o),
        .flush_i   (flush_i),
        .instr_o   (iss_instr),
        .tag_o     (iss_tag),
        .mem_req_o (mem_req_o)
    );

    pending_mem_req_queue #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_pending_mem_req_queue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instruction_i  (iss_instr),
        .tag_i          (iss_tag),
        .replay_valid_i (replay_valid),
        .tag_next_i     (replay_tag),
        .replay_data_i  (replay_data),
        .flush_i        (flush_i),
        .advance_head_i (advance_head),
        .finish_instr_o (head_instr),
        .full_o         (full_o)
    );

    load_response_unit i_load_response_unit (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .mem_resp_i     (mem_resp_i),
        .alloc_valid_i  (alloc_valid),
        .alloc_tag_i    (iss_tag),
        .size_i         (iss_instr.size),
        .is_signed_i    (iss_instr.is_signed),
        .byte_off_i     (iss_instr.addr[2:0]),
        .replay_valid_o (replay_valid),
        .replay_tag_o   (replay_tag),
        .replay_data_o  (replay_data)
    );

    wb_drain i_wb_drain (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .finish_instr_i (head_instr),
        .advance_head_o (advance_head),
        .wb_o           (wb_o)
    );

endmodule

// File: verif/tb_mem_load_unit.sv
// Load path testbench with clock, reset, memory responder, load stimulus and assertion checks
module tb_mem_load_unit import pmrq_pkg::*; ();

    localparam int NUM_ENTRIES = 8;
    localparam int THR         = NUM_ENTRIES - 3;   // Early full level
    localparam int DRV         = 10;                // Input skew after the rising edge
    localparam int N_RAND      = 48;
    localparam int STIM_LEN    = 8 + 10 * (N_RAND + 16) + 40;
    localparam int LIMIT       = 2 * STIM_LEN + 200;

    typedef struct packed {
        reg_addr_t rd;
        bus64_t    data;
        logic      exc;
    } exp_wb_t;

    typedef struct packed {
        pmrq_tag_t   tag;
        bus64_t      addr;
        logic [31:0] due;   // Cycle at which memory may answer
    } mem_job_t;

    logic        clk_i;
    logic        rstn_i;
    load_instr_t instr_i;
    logic        flush_i;
    mem_resp_t   mem_resp_i;
    mem_req_t    mem_req_o;
    wb_t         wb_o;
    logic        full_o;

    exp_wb_t  exp_q [$];     // Writebacks in acceptance order
    mem_job_t job_q [$];     // Requests memory still owes
    exp_wb_t  exp_front;
    logic     exp_any;
    int       sb_count;
    logic [15:0] lfsr;
    int unsigned cycle;
    int unsigned errors;
    int unsigned wb_seen;
    logic hold_resp;         // Memory withholds answers
    logic fast_resp;         // Answer in the next cycle
    logic lat_probe;
    logic tag0_pending;      // Next request must carry tag 0
    logic idle_phase;
    logic acc_aligned;       // Aligned load accepted at the coming edge
    mem_size_e req_size_exp; // Size of the last accepted load

    mem_load_unit_top #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_mem_load_unit_top (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .instr_i    (instr_i),
        .flush_i    (flush_i),
        .mem_resp_i (mem_resp_i),
        .mem_req_o  (mem_req_o),
        .wb_o       (wb_o),
        .full_o     (full_o)
    );

    always #50 clk_i = ~clk_i;

    // Memory contents depend on every address bit
    function automatic bus64_t mem_word(bus64_t a);
        return (a * 64'h9E37_79B9_7F4A_7C15) ^ {a[31:0], a[63:32]};
    endfunction

    // Pick the addressed lane and extend it
    function automatic bus64_t extend(bus64_t w, logic [2:0] off, mem_size_e sz, logic sgn);
        bus64_t v;
        bus64_t mask;
        int     nbits;
        nbits = 8 << sz;
        v     = w >> (8 * off);
        if (nbits < 64) begin
            mask = (64'd1 << nbits) - 64'd1;
            v    = v & mask;
            if (sgn && v[nbits-1]) begin
                v = v | ~mask;
            end
        end
        return v;
    endfunction

    // Galois LFSR stepped once per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic refresh_front();
        sb_count  = exp_q.size();
        exp_any   = (sb_count != 0);
        exp_front = exp_any ? exp_q[0] : '0;
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Check failed: %s at cycle %0d", what, cycle);
    endtask

    // Drives one load a skew after an edge
    task automatic issue_load(input mem_size_e sz, input logic sgn, input logic misal,
                              input reg_addr_t rd);
        logic [31:0] r;
        bus64_t      addr;
        logic [11:0] off;
        while (full_o) begin
            @(posedge clk_i);
            #DRV;
        end
        rand_bits(32, r);
        addr = {32'h8000_0000, r} & ~((64'd1 << sz) - 64'd1);
        if (misal) begin
            addr[0] = 1'b1;
        end
        rand_bits(12, r);
        off               = r[11:0];
        instr_i           = '0;
        instr_i.valid     = 1'b1;
        instr_i.base      = addr - {{52{off[11]}}, off};
        instr_i.offset    = off;
        instr_i.rd        = rd;
        instr_i.size      = sz;
        instr_i.is_signed = sgn;
        acc_aligned       = ~misal;
        idle_phase        = 1'b0;
        @(posedge clk_i);
        #DRV;
        instr_i.valid = 1'b0;
        acc_aligned   = 1'b0;
        req_size_exp  = sz;     // Request pulse comes at the next edge
        exp_q.push_back('{rd: rd, exc: misal,
            data: misal ? '0 : extend(mem_word({addr[63:3], 3'b000}), addr[2:0], sz, sgn)});
        refresh_front();
    endtask

    task automatic rand_load();
        logic [31:0] r;
        mem_size_e   sz;
        rand_bits(11, r);
        sz = mem_size_e'(r[1:0]);
        issue_load(sz, r[2], (r[5:3] == 3'd0) && (sz != SIZE_B), r[10:6]);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || job_q.size() != 0) begin
            @(posedge clk_i);
            #DRV;
        end
    endtask

    task automatic report(input logic timed_out);
        $display("Summary: %0d writebacks, %0d errors, %0d cycles", wb_seen, errors, cycle);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // Memory model and scoreboard pop
    always @(posedge clk_i) begin
        int          pick;
        logic [31:0] d;
        cycle++;
        if (rstn_i && wb_o.valid) begin
            wb_seen++;
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            refresh_front();
        end
        if (rstn_i && mem_req_o.valid) begin
            tag0_pending = 1'b0;
            rand_bits(3, d);
            job_q.push_back('{tag: mem_req_o.tag, addr: mem_req_o.addr,
                due: cycle + (fast_resp ? 0 : (d % 6) + 1)});
        end
        #DRV;
        mem_resp_i = '0;
        pick       = -1;
        if (!hold_resp) begin
            foreach (job_q[i]) begin
                if (pick < 0 && job_q[i].due <= cycle) begin
                    pick = i;  // Oldest due job wins
                end
            end
        end
        if (pick >= 0) begin
            mem_resp_i = '{valid: 1'b1, tag: job_q[pick].tag, data: mem_word(job_q[pick].addr)};
            job_q.delete(pick);
        end
    end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |-> full_o && !wb_o.valid && !mem_req_o.valid)
        else note_failure("outputs active during reset");
    a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        idle_phase |-> !wb_o.valid && !mem_req_o.valid)
        else note_failure("output pulse before any load");
    a_wb_expected: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.valid |-> exp_any)
        else note_failure("writeback with no load pending");
    a_wb_rd: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.valid && exp_any |-> wb_o.rd == exp_front.rd)
        else begin
            errors++;
            $display("FAILED wb_o.rd got %h expected %h", $sampled(wb_o.rd), $sampled(exp_front.rd));
        end
    a_wb_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.valid && exp_any |-> wb_o.data == exp_front.data)
        else begin
            errors++;
            $display("FAILED wb_o.data got %h expected %h",
                $sampled(wb_o.data), $sampled(exp_front.data));
        end
    a_wb_exc: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.valid && exp_any |-> wb_o.exception == exp_front.exc)
        else begin
            errors++;
            $display("FAILED wb_o.exception got %h expected %h",
                $sampled(wb_o.exception), $sampled(exp_front.exc));
        end
    a_req_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        1'b1 |=> mem_req_o.valid == $past(acc_aligned))
        else note_failure("memory request pulse does not follow an aligned load");
    a_req_size: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_o.valid |-> mem_req_o.size == req_size_exp)
        else begin
            errors++;
            $display("FAILED mem_req_o.size got %h expected %h",
                $sampled(mem_req_o.size), $sampled(req_size_exp));
        end
    a_lat_min: assert property (@(posedge clk_i) disable iff (!rstn_i)
        lat_probe && wb_o.valid |-> $past(mem_resp_i.valid, 3))
        else note_failure("writeback not 3 cycles after its response");
    a_lat_max: assert property (@(posedge clk_i) disable iff (!rstn_i)
        lat_probe && $past(mem_resp_i.valid, 3) |-> wb_o.valid)
        else note_failure("writeback missing 3 cycles after the response");
    a_full_thr: assert property (@(posedge clk_i) disable iff (!rstn_i)
        hold_resp && !flush_i |-> full_o == (sb_count >= THR))
        else begin
            errors++;
            $display("FAILED full_o got %h expected %h", $sampled(full_o), $sampled(sb_count >= THR));
        end
    a_tag0: assert property (@(posedge clk_i) disable iff (!rstn_i)
        tag0_pending && mem_req_o.valid |-> mem_req_o.tag == '0)
        else begin
            errors++;
            $display("FAILED mem_req_o.tag got %h expected %h", $sampled(mem_req_o.tag), 4'h0);
        end

    initial begin
        wait (cycle >= LIMIT);
        $display("Run stopped: no progress within %0d cycles", LIMIT);
        report(1'b1);
    end

    initial begin
        clk_i  = 1'b0;
        rstn_i = 1'b0;
        instr_i = '0;
        flush_i = 1'b0;
        mem_resp_i = '0;
        lfsr = 16'd13087;
        {cycle, errors, wb_seen} = '0;
        {hold_resp, fast_resp, lat_probe, tag0_pending, acc_aligned} = '0;
        req_size_exp = SIZE_B;
        idle_phase = 1'b1;
        refresh_front();
        repeat (8) @(posedge clk_i);
        #DRV;
        rstn_i = 1'b1;
        repeat (3) @(posedge clk_i);
        #DRV;
        // Lone load answered at once
        lat_probe = 1'b1;
        fast_resp = 1'b1;
        issue_load(SIZE_W, 1'b1, 1'b0, 5'd1);
        wait_drain();
        lat_probe = 1'b0;
        fast_resp = 1'b0;
        repeat (N_RAND) rand_load();
        wait_drain();
        issue_load(SIZE_H, 1'b0, 1'b1, 5'd2);  // Misaligned mixed with aligned
        issue_load(SIZE_D, 1'b1, 1'b0, 5'd3);
        issue_load(SIZE_W, 1'b0, 1'b1, 5'd4);
        issue_load(SIZE_D, 1'b0, 1'b1, 5'd5);
        wait_drain();
        // Fill to the early threshold
        @(posedge clk_i);
        hold_resp = 1'b1;
        #DRV;
        for (int i = 0; i < THR; i++) begin
            issue_load(SIZE_D, 1'b0, 1'b0, reg_addr_t'(i + 8));
        end
        repeat (4) @(posedge clk_i);
        hold_resp = 1'b0;
        #DRV;
        issue_load(SIZE_B, 1'b1, 1'b0, 5'd20);  // Waits for full_o to drop
        wait_drain();
        // Flush with requests withheld
        @(posedge clk_i);
        hold_resp = 1'b1;
        #DRV;
        for (int i = 0; i < 3; i++) begin
            issue_load(SIZE_W, 1'b1, 1'b0, reg_addr_t'(i + 24));
        end
        repeat (3) @(posedge clk_i);
        #DRV;
        flush_i = 1'b1;
        @(posedge clk_i);
        job_q.delete();
        exp_q.delete();
        refresh_front();
        hold_resp = 1'b0;
        #DRV;
        flush_i      = 1'b0;
        tag0_pending = 1'b1;
        repeat (4) @(posedge clk_i);
        #DRV;
        issue_load(SIZE_B, 1'b1, 1'b0, 5'd30);
        wait_drain();
        repeat (3) @(posedge clk_i);
        report(1'b0);
    end

endmodule

// File: sim.f
src/pmrq_pkg.sv
src/load_issue_unit.sv
src/pending_mem_req_queue.sv
src/load_response_unit.sv
src/wb_drain.sv
src/mem_load_unit_top.sv
verif/tb_mem_load_unit.sv

// File: Makefile
# Verilator build and run of the load path testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_load_unit
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
